// File: design/mmu_pkg.sv
// SV39 data MMU shared definitions
// address widths, TLB geometry, page fault causes and the bundles between blocks
package mmu_pkg;

    // --------------------
    // address geometry
    // --------------------
    localparam int unsigned VLEN      = 39;
    localparam int unsigned PLEN      = 56;
    localparam int unsigned PPNW      = 44;
    // one level of the three-level SV39 vpn
    localparam int unsigned VPN_W     = 9;
    localparam int unsigned PG_OFFS_W = 12;
    localparam int unsigned ASID_W    = 4;

    // --------------------
    // TLB geometry
    // --------------------
    localparam int unsigned TLB_ENTRIES = 4;
    localparam int unsigned TLB_IDX_W   = 2;

    // exception cause codes, as in the privileged spec
    localparam int unsigned CAUSE_W = 4;
    localparam logic [CAUSE_W-1:0] CAUSE_LOAD_PAGE_FAULT  = 4'd13;
    localparam logic [CAUSE_W-1:0] CAUSE_STORE_PAGE_FAULT = 4'd15;

    typedef enum logic [1:0] {
        PRIV_LVL_U = 2'd0,
        PRIV_LVL_S = 2'd1,
        PRIV_LVL_M = 2'd3
    } priv_lvl_t;

    // leaf pte fields kept in the TLB, rsw dropped
    typedef struct packed {
        logic [PPNW-1:0] ppn;
        logic            d;
        logic            a;
        logic            g;
        logic            u;
        logic            x;
        logic            w;
        logic            r;
        logic            v;
    } pte_t;

    // refill write from the external walker
    typedef struct packed {
        logic                 valid;
        logic                 is_2m;
        logic                 is_1g;
        logic [3*VPN_W-1:0]   vpn;
        logic [ASID_W-1:0]    asid;
        pte_t                 content;
    } tlb_update_t;

    typedef struct packed {
        logic            req;
        logic [VLEN-1:0] vaddr;
        logic            is_store;
    } lsu_req_t;

    // stage one result handed to stage two
    typedef struct packed {
        logic            req;
        logic            is_store;
        logic [VLEN-1:0] vaddr;
        logic            hit;
        logic            is_2m;
        logic            is_1g;
        pte_t            pte;
    } lookup_t;

    typedef struct packed {
        logic [CAUSE_W-1:0] cause;
        logic [VLEN-1:0]    tval;
        logic               valid;
    } exception_t;

    typedef struct packed {
        logic            valid;
        logic [PLEN-1:0] paddr;
        logic            miss;
        exception_t      ex;
    } lsu_resp_t;

endpackage

// File: design/dtlb.sv
// fully associative data TLB for SV39 with 4K/2M/1G pages and ASID tags
// combinational lookup, round-robin refill, SFENCE.VMA style flush
`timescale 1ns/1ps

module dtlb (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               lu_access_i,
    input  logic [mmu_pkg::ASID_W-1:0]         lu_asid_i,
    input  logic [mmu_pkg::VLEN-1:0]           lu_vaddr_i,
    input  mmu_pkg::tlb_update_t               update_i,
    input  logic                               flush_i,
    input  logic [mmu_pkg::ASID_W-1:0]         flush_asid_i,
    input  logic [mmu_pkg::VLEN-1:0]           flush_vaddr_i,
    output logic                               lu_hit_o,
    output logic                               lu_is_2m_o,
    output logic                               lu_is_1g_o,
    output mmu_pkg::pte_t                      lu_content_o
);

    // tag storage, only the valid bits and the victim pointer are reset
    logic [mmu_pkg::TLB_ENTRIES-1:0]   valid_q;
    logic [mmu_pkg::TLB_ENTRIES-1:0]   is_2m_q;
    logic [mmu_pkg::TLB_ENTRIES-1:0]   is_1g_q;
    logic [3*mmu_pkg::VPN_W-1:0]       vpn_q     [mmu_pkg::TLB_ENTRIES];
    logic [mmu_pkg::ASID_W-1:0]        asid_q    [mmu_pkg::TLB_ENTRIES];
    mmu_pkg::pte_t                     content_q [mmu_pkg::TLB_ENTRIES];
    logic [mmu_pkg::TLB_IDX_W-1:0]     rr_q;

    logic [mmu_pkg::TLB_ENTRIES-1:0]   flush_clr;
    logic [mmu_pkg::TLB_IDX_W-1:0]     victim;
    logic                              all_valid;
    logic                              do_update;

    // vpn compare honouring superpages: vpn[2] always, vpn[1] unless 1G,
    // vpn[0] unless 2M or 1G
    function automatic logic page_match(input logic [3*mmu_pkg::VPN_W-1:0] tag,
                                        input logic                        is_2m,
                                        input logic                        is_1g,
                                        input logic [3*mmu_pkg::VPN_W-1:0] vpn);
        logic m2;
        logic m1;
        logic m0;
        m2 = tag[3*mmu_pkg::VPN_W-1:2*mmu_pkg::VPN_W] == vpn[3*mmu_pkg::VPN_W-1:2*mmu_pkg::VPN_W];
        m1 = tag[2*mmu_pkg::VPN_W-1:mmu_pkg::VPN_W] == vpn[2*mmu_pkg::VPN_W-1:mmu_pkg::VPN_W];
        m0 = tag[mmu_pkg::VPN_W-1:0] == vpn[mmu_pkg::VPN_W-1:0];
        return m2 && (is_1g || m1) && (is_1g || is_2m || m0);
    endfunction

    // --------------------
    // lookup
    // --------------------
    always_comb begin : lookup
        lu_hit_o     = 1'b0;
        lu_is_2m_o   = 1'b0;
        lu_is_1g_o   = 1'b0;
        lu_content_o = '0;
        // walk downwards so the lowest matching index wins
        for (int i = mmu_pkg::TLB_ENTRIES - 1; i >= 0; i--) begin
            if (valid_q[i] && (asid_q[i] == lu_asid_i || content_q[i].g) &&
                page_match(vpn_q[i], is_2m_q[i], is_1g_q[i],
                           lu_vaddr_i[mmu_pkg::VLEN-1:mmu_pkg::PG_OFFS_W])) begin
                lu_hit_o     = lu_access_i;
                lu_is_2m_o   = is_2m_q[i];
                lu_is_1g_o   = is_1g_q[i];
                lu_content_o = content_q[i];
            end
        end
    end

    // --------------------
    // flush select
    // --------------------
    always_comb begin : flush_sel
        logic asid_zero;
        logic vaddr_zero;
        logic vmatch;
        logic amatch;
        asid_zero  = flush_asid_i == '0;
        vaddr_zero = flush_vaddr_i == '0;
        for (int i = 0; i < mmu_pkg::TLB_ENTRIES; i++) begin
            vmatch = page_match(vpn_q[i], is_2m_q[i], is_1g_q[i],
                                flush_vaddr_i[mmu_pkg::VLEN-1:mmu_pkg::PG_OFFS_W]);
            amatch = asid_q[i] == flush_asid_i;
            case ({asid_zero, vaddr_zero})
                2'b11:   flush_clr[i] = 1'b1;
                2'b10:   flush_clr[i] = vmatch;
                // global pages survive an ASID scoped flush
                2'b01:   flush_clr[i] = !content_q[i].g && amatch;
                default: flush_clr[i] = !content_q[i].g && amatch && vmatch;
            endcase
        end
    end

    // refill victim: first free entry, round-robin once full
    always_comb begin : victim_sel
        all_valid = &valid_q;
        victim    = rr_q;
        for (int i = mmu_pkg::TLB_ENTRIES - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                victim = mmu_pkg::TLB_IDX_W'(i);
            end
        end
    end

    // a flush in the same cycle drops the refill
    assign do_update = update_i.valid && !flush_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            rr_q    <= '0;
        end else if (flush_i) begin
            valid_q <= valid_q & ~flush_clr;
        end else if (do_update) begin
            valid_q[victim] <= 1'b1;
            if (all_valid) begin
                rr_q <= rr_q + 1'b1;
            end
        end
    end

    // entry payload
    always_ff @(posedge clk_i) begin
        if (do_update) begin
            is_2m_q[victim]   <= update_i.is_2m;
            is_1g_q[victim]   <= update_i.is_1g;
            vpn_q[victim]     <= update_i.vpn;
            asid_q[victim]    <= update_i.asid;
            content_q[victim] <= update_i.content;
        end
    end

endmodule

// File: design/lookup_stage.sv
// MMU stage one: data TLB lookup, early hit/ppn and the lookup register
`timescale 1ns/1ps

module lookup_stage (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        en_translation_i,
    input  logic [mmu_pkg::ASID_W-1:0]  asid_i,
    input  mmu_pkg::lsu_req_t           req_i,
    input  mmu_pkg::tlb_update_t        update_i,
    input  logic                        flush_i,
    input  logic [mmu_pkg::ASID_W-1:0]  flush_asid_i,
    input  logic [mmu_pkg::VLEN-1:0]    flush_vaddr_i,
    output logic                        dtlb_hit_o,
    output logic [mmu_pkg::PPNW-1:0]    dtlb_ppn_o,
    output logic                        dtlb_miss_o,
    output mmu_pkg::lookup_t            lookup_o
);

    localparam int unsigned MEGA_HI = mmu_pkg::PG_OFFS_W + mmu_pkg::VPN_W - 1;
    localparam int unsigned GIGA_HI = mmu_pkg::PG_OFFS_W + 2 * mmu_pkg::VPN_W - 1;

    logic               tlb_hit;
    logic               tlb_is_2m;
    logic               tlb_is_1g;
    mmu_pkg::pte_t      tlb_content;

    logic               req_q;
    logic               miss_q;
    logic               is_store_q;
    logic [mmu_pkg::VLEN-1:0] vaddr_q;
    logic               hit_q;
    logic               is_2m_q;
    logic               is_1g_q;
    mmu_pkg::pte_t      pte_q;

    // the tlb only reports a hit for a live translated request
    dtlb i_dtlb (
        .clk_i         ( clk_i                            ),
        .rst_ni        ( rst_ni                           ),
        .lu_access_i   ( req_i.req && en_translation_i    ),
        .lu_asid_i     ( asid_i                           ),
        .lu_vaddr_i    ( req_i.vaddr                      ),
        .update_i      ( update_i                         ),
        .flush_i       ( flush_i                          ),
        .flush_asid_i  ( flush_asid_i                     ),
        .flush_vaddr_i ( flush_vaddr_i                    ),
        .lu_hit_o      ( tlb_hit                          ),
        .lu_is_2m_o    ( tlb_is_2m                        ),
        .lu_is_1g_o    ( tlb_is_1g                        ),
        .lu_content_o  ( tlb_content                      )
    );

    // --------------------
    // early outputs, same cycle as the request
    // --------------------
    always_comb begin : early_out
        dtlb_hit_o = en_translation_i ? tlb_hit : 1'b1;
        if (en_translation_i) begin
            dtlb_ppn_o = tlb_content.ppn;
            // superpages take the low vpn levels from the address
            if (tlb_is_2m) begin
                dtlb_ppn_o[mmu_pkg::VPN_W-1:0] = req_i.vaddr[MEGA_HI:mmu_pkg::PG_OFFS_W];
            end
            if (tlb_is_1g) begin
                dtlb_ppn_o[2*mmu_pkg::VPN_W-1:0] = req_i.vaddr[GIGA_HI:mmu_pkg::PG_OFFS_W];
            end
        end else begin
            // bare mode, page number of the address itself
            dtlb_ppn_o = mmu_pkg::PPNW'(req_i.vaddr[mmu_pkg::VLEN-1:mmu_pkg::PG_OFFS_W]);
        end
    end

    // --------------------
    // lookup register
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q  <= 1'b0;
            miss_q <= 1'b0;
        end else begin
            req_q  <= req_i.req;
            // perf strobe, one pulse per translated miss
            miss_q <= req_i.req && en_translation_i && !tlb_hit;
        end
    end

    always_ff @(posedge clk_i) begin
        is_store_q <= req_i.is_store;
        vaddr_q    <= req_i.vaddr;
        hit_q      <= tlb_hit;
        is_2m_q    <= tlb_is_2m;
        is_1g_q    <= tlb_is_1g;
        pte_q      <= tlb_content;
    end

    assign dtlb_miss_o = miss_q;
    assign lookup_o    = '{req: req_q, is_store: is_store_q, vaddr: vaddr_q, hit: hit_q,
                           is_2m: is_2m_q, is_1g: is_1g_q, pte: pte_q};

endmodule

// File: design/translate_stage.sv
// MMU stage two: physical address build, permission check and response
// purely combinational on the registered lookup
`timescale 1ns/1ps

module translate_stage (
    input  logic                  en_translation_i,
    input  mmu_pkg::priv_lvl_t    priv_lvl_i,
    input  logic                  sum_i,
    input  mmu_pkg::lookup_t      lookup_i,
    output mmu_pkg::lsu_resp_t    resp_o
);

    localparam int unsigned MEGA_HI = mmu_pkg::PG_OFFS_W + mmu_pkg::VPN_W - 1;
    localparam int unsigned GIGA_HI = mmu_pkg::PG_OFFS_W + 2 * mmu_pkg::VPN_W - 1;

    logic                     access_err;
    logic [mmu_pkg::PLEN-1:0] paddr_tr;

    // --------------------
    // privilege check
    // --------------------
    // S mode touches a user page only with SUM set,
    // U mode touches user pages only
    always_comb begin : priv_check
        access_err = 1'b0;
        if (priv_lvl_i == mmu_pkg::PRIV_LVL_S && !sum_i && lookup_i.pte.u) begin
            access_err = 1'b1;
        end
        if (priv_lvl_i == mmu_pkg::PRIV_LVL_U && !lookup_i.pte.u) begin
            access_err = 1'b1;
        end
    end

    // --------------------
    // physical address
    // --------------------
    always_comb begin : paddr_build
        // 4K page
        paddr_tr = {lookup_i.pte.ppn, lookup_i.vaddr[mmu_pkg::PG_OFFS_W-1:0]};
        // mega page keeps vpn[0] of the address
        if (lookup_i.is_2m) begin
            paddr_tr[MEGA_HI:mmu_pkg::PG_OFFS_W] =
                lookup_i.vaddr[MEGA_HI:mmu_pkg::PG_OFFS_W];
        end
        // giga page keeps vpn[1:0]
        if (lookup_i.is_1g) begin
            paddr_tr[GIGA_HI:mmu_pkg::PG_OFFS_W] =
                lookup_i.vaddr[GIGA_HI:mmu_pkg::PG_OFFS_W];
        end
    end

    // --------------------
    // response
    // --------------------
    always_comb begin : resp_build
        resp_o       = '0;
        // one response per request, hit, miss or fault
        resp_o.valid = lookup_i.req;

        if (!en_translation_i) begin
            // bare mode
            resp_o.paddr = mmu_pkg::PLEN'(lookup_i.vaddr);
        end else begin
            resp_o.paddr = paddr_tr;
            if (!lookup_i.hit) begin
                // requester refills and retries
                resp_o.miss = lookup_i.req;
            end else begin
                // a registered hit always belongs to a live request
                if (lookup_i.is_store) begin
                    // store needs W and D set, dirty tracking is left to software
                    if (!lookup_i.pte.w || !lookup_i.pte.d || access_err) begin
                        resp_o.ex = '{cause: mmu_pkg::CAUSE_STORE_PAGE_FAULT,
                                      tval:  lookup_i.vaddr,
                                      valid: 1'b1};
                    end
                end else begin
                    // no MXR, a load only checks privilege
                    if (access_err) begin
                        resp_o.ex = '{cause: mmu_pkg::CAUSE_LOAD_PAGE_FAULT,
                                      tval:  lookup_i.vaddr,
                                      valid: 1'b1};
                    end
                end
            end
        end
    end

endmodule

// File: design/dmmu.sv
// SV39 data MMU top, two-stage lookup and translate pipeline
`timescale 1ns/1ps

module dmmu (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        en_translation_i,
    input  mmu_pkg::priv_lvl_t          priv_lvl_i,
    input  logic                        sum_i,
    input  logic [mmu_pkg::ASID_W-1:0]  asid_i,
    input  mmu_pkg::lsu_req_t           req_i,
    input  mmu_pkg::tlb_update_t        update_i,
    input  logic                        flush_i,
    input  logic [mmu_pkg::ASID_W-1:0]  flush_asid_i,
    input  logic [mmu_pkg::VLEN-1:0]    flush_vaddr_i,
    output logic                        dtlb_hit_o,
    output logic [mmu_pkg::PPNW-1:0]    dtlb_ppn_o,
    output mmu_pkg::lsu_resp_t          resp_o,
    output logic                        dtlb_miss_o
);

    // stage one to stage two
    mmu_pkg::lookup_t lookup;

    lookup_stage i_lookup_stage (
        .clk_i, .rst_ni, .en_translation_i, .asid_i, .req_i, .update_i,
        .flush_i, .flush_asid_i, .flush_vaddr_i,
        .dtlb_hit_o, .dtlb_ppn_o, .dtlb_miss_o,
        .lookup_o ( lookup )
    );

    translate_stage i_translate_stage (
        .en_translation_i, .priv_lvl_i, .sum_i,
        .lookup_i ( lookup ),
        .resp_o
    );

endmodule

// File: testbench/dmmu_checker.sv
// response checker for the data MMU
// compares early TLB outputs and the stage two response with the model
`timescale 1ns/1ps

module dmmu_checker (
    input  logic                       clk_i,
    input  logic                       chk_en_i,
    // DUT side
    input  logic                       hit_i,
    input  logic [mmu_pkg::PPNW-1:0]   ppn_i,
    input  mmu_pkg::lsu_resp_t         resp_i,
    input  logic                       miss_i,
    // model side
    input  logic                       exp_hit_i,
    input  logic [mmu_pkg::PPNW-1:0]   exp_ppn_i,
    input  logic                       ppn_chk_i,
    input  mmu_pkg::lsu_resp_t         exp_resp_i,
    input  logic                       paddr_chk_i,
    input  logic                       ex_chk_i,
    input  logic                       exp_miss_i,
    output int unsigned                err_cnt_o,
    output int unsigned                chk_cnt_o
);

    int unsigned errors = 0;
    int unsigned checks = 0;

    // one field against its expected value
    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    // --------------------
    // sample mid cycle
    // --------------------
    // inputs move 2 ns after the rising edge, the falling edge sees settled outputs
    always @(negedge clk_i) begin
        if (chk_en_i) begin
            compare("dtlb_hit_o", 64'(hit_i), 64'(exp_hit_i));
            // ppn is only defined on a single unambiguous hit or in bare mode
            if (ppn_chk_i) begin
                compare("dtlb_ppn_o", 64'(ppn_i), 64'(exp_ppn_i));
            end
            compare("dtlb_miss_o", 64'(miss_i), 64'(exp_miss_i));
            compare("resp_o.valid", 64'(resp_i.valid), 64'(exp_resp_i.valid));
            compare("resp_o.miss", 64'(resp_i.miss), 64'(exp_resp_i.miss));
            if (paddr_chk_i) begin
                compare("resp_o.paddr", 64'(resp_i.paddr), 64'(exp_resp_i.paddr));
            end
            if (ex_chk_i) begin
                compare("resp_o.ex.valid", 64'(resp_i.ex.valid), 64'(exp_resp_i.ex.valid));
                compare("resp_o.ex.cause", 64'(resp_i.ex.cause), 64'(exp_resp_i.ex.cause));
                compare("resp_o.ex.tval", 64'(resp_i.ex.tval), 64'(exp_resp_i.ex.tval));
            end
        end
    end

    assign err_cnt_o = errors;
    assign chk_cnt_o = checks;

endmodule

// File: testbench/tb_dmmu.sv
// testbench for the SV39 data MMU
// LCG traffic against a reference TLB, results compared in dmmu_checker
`timescale 1ns/1ps

module tb_dmmu;

    localparam int unsigned NUM_CYCLES     = 800;
    localparam int unsigned BARE_CYCLES    = 40;
    localparam int unsigned PHASE_CYCLES   = 200;
    localparam int unsigned TIMEOUT_CYCLES = 2000;

    logic                        clk_i;
    logic                        rst_ni;
    logic                        en_translation;
    mmu_pkg::priv_lvl_t          priv_lvl;
    logic                        sum;
    logic [mmu_pkg::ASID_W-1:0]  asid;
    mmu_pkg::lsu_req_t           req;
    mmu_pkg::tlb_update_t        update;
    logic                        flush;
    logic [mmu_pkg::ASID_W-1:0]  flush_asid;
    logic [mmu_pkg::VLEN-1:0]    flush_vaddr;
    logic                        dtlb_hit;
    logic [mmu_pkg::PPNW-1:0]    dtlb_ppn;
    mmu_pkg::lsu_resp_t          resp;
    logic                        dtlb_miss;

    // expected values handed to the checker
    logic                        chk_en;
    logic                        exp_hit;
    logic [mmu_pkg::PPNW-1:0]    exp_ppn;
    logic                        ppn_chk;
    mmu_pkg::lsu_resp_t          exp_resp;
    logic                        paddr_chk;
    logic                        ex_chk;
    logic                        exp_miss;
    int unsigned                 err_cnt;
    int unsigned                 chk_cnt;

    // --------------------
    // reference TLB
    // --------------------
    logic                           m_valid [mmu_pkg::TLB_ENTRIES];
    logic                           m_2m    [mmu_pkg::TLB_ENTRIES];
    logic                           m_1g    [mmu_pkg::TLB_ENTRIES];
    logic [3*mmu_pkg::VPN_W-1:0]    m_vpn   [mmu_pkg::TLB_ENTRIES];
    logic [mmu_pkg::ASID_W-1:0]     m_asid  [mmu_pkg::TLB_ENTRIES];
    mmu_pkg::pte_t                  m_pte   [mmu_pkg::TLB_ENTRIES];
    logic [mmu_pkg::TLB_IDX_W-1:0]  m_rr;

    // stage one result of this cycle (s1) and the registered one (p1)
    mmu_pkg::lookup_t               s1;
    mmu_pkg::lookup_t               p1;
    logic                           s1_amb;
    logic                           p1_amb;
    logic                           s1_missp;
    logic                           p1_missp;
    logic [3*mmu_pkg::VPN_W-1:0]    last_miss_vpn;
    logic                           have_miss;
    logic [31:0]                    lcg_state;

    dmmu i_dmmu (
        .clk_i            ( clk_i          ),
        .rst_ni           ( rst_ni         ),
        .en_translation_i ( en_translation ),
        .priv_lvl_i       ( priv_lvl       ),
        .sum_i            ( sum            ),
        .asid_i           ( asid           ),
        .req_i            ( req            ),
        .update_i         ( update         ),
        .flush_i          ( flush          ),
        .flush_asid_i     ( flush_asid     ),
        .flush_vaddr_i    ( flush_vaddr    ),
        .dtlb_hit_o       ( dtlb_hit       ),
        .dtlb_ppn_o       ( dtlb_ppn       ),
        .resp_o           ( resp           ),
        .dtlb_miss_o      ( dtlb_miss      )
    );

    dmmu_checker i_checker (
        .clk_i       ( clk_i     ),
        .chk_en_i    ( chk_en    ),
        .hit_i       ( dtlb_hit  ),
        .ppn_i       ( dtlb_ppn  ),
        .resp_i      ( resp      ),
        .miss_i      ( dtlb_miss ),
        .exp_hit_i   ( exp_hit   ),
        .exp_ppn_i   ( exp_ppn   ),
        .ppn_chk_i   ( ppn_chk   ),
        .exp_resp_i  ( exp_resp  ),
        .paddr_chk_i ( paddr_chk ),
        .ex_chk_i    ( ex_chk    ),
        .exp_miss_i  ( exp_miss  ),
        .err_cnt_o   ( err_cnt   ),
        .chk_cnt_o   ( chk_cnt   )
    );

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // --------------------
    // random numbers
    // --------------------
    function automatic logic [31:0] rand_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // low LCG bits are weak, take them from the middle
    function automatic int unsigned rand_below(input int unsigned n);
        return (rand_next() >> 8) % n;
    endfunction

    function automatic logic rand_bit();
        return rand_below(2) == 1;
    endfunction

    // small address pool, three values per vpn level, so entries get reused
    function automatic logic [mmu_pkg::VLEN-1:0] pool_vaddr();
        logic [mmu_pkg::VLEN-1:0] va;
        va = {9'(rand_below(3)), 9'(rand_below(3)), 9'(rand_below(3)), 12'(rand_below(4096))};
        return va;
    endfunction

    // --------------------
    // model rules
    // --------------------
    // a 1G page ignores vpn[1:0], a 2M page ignores vpn[0]
    function automatic logic vpn_covers(input int i, input logic [3*mmu_pkg::VPN_W-1:0] vpn);
        logic same2;
        logic same1;
        logic same0;
        same2 = m_vpn[i][26:18] == vpn[26:18];
        same1 = m_vpn[i][17:9] == vpn[17:9];
        same0 = m_vpn[i][8:0] == vpn[8:0];
        return same2 && (m_1g[i] || same1) && (m_1g[i] || m_2m[i] || same0);
    endfunction

    function automatic logic flush_hits(input int i);
        logic vm;
        logic am;
        vm = vpn_covers(i, flush_vaddr[mmu_pkg::VLEN-1:mmu_pkg::PG_OFFS_W]);
        am = m_asid[i] == flush_asid;
        if (flush_asid == '0 && flush_vaddr == '0) begin
            return 1'b1;
        end else if (flush_asid == '0) begin
            return vm;
        end else if (flush_vaddr == '0) begin
            return !m_pte[i].g && am;
        end
        return !m_pte[i].g && am && vm;
    endfunction

    task automatic model_reset();
        for (int i = 0; i < int'(mmu_pkg::TLB_ENTRIES); i++) begin
            m_valid[i] = 1'b0;
        end
        m_rr      = '0;
        s1        = '0;
        p1        = '0;
        s1_amb    = 1'b0;
        p1_amb    = 1'b0;
        s1_missp  = 1'b0;
        p1_missp  = 1'b0;
        have_miss = 1'b0;
    endtask

    // what the rising edge does to the model, inputs are still the old ones
    task automatic model_clock();
        int victim;
        logic full;
        p1       = s1;
        p1_amb   = s1_amb;
        p1_missp = s1_missp;
        if (flush) begin
            for (int i = 0; i < int'(mmu_pkg::TLB_ENTRIES); i++) begin
                if (flush_hits(i)) begin
                    m_valid[i] = 1'b0;
                end
            end
        end else if (update.valid) begin
            // first free slot, otherwise the round-robin slot
            victim = -1;
            full   = 1'b1;
            for (int i = 0; i < int'(mmu_pkg::TLB_ENTRIES); i++) begin
                if (!m_valid[i] && victim < 0) begin
                    victim = i;
                    full   = 1'b0;
                end
            end
            if (full) begin
                victim = int'(m_rr);
                m_rr   = m_rr + 1'b1;
            end
            m_valid[victim] = 1'b1;
            m_2m[victim]    = update.is_2m;
            m_1g[victim]    = update.is_1g;
            m_vpn[victim]   = update.vpn;
            m_asid[victim]  = update.asid;
            m_pte[victim]   = update.content;
        end
    endtask

    // expected early outputs for this cycle and the response for the registered request
    task automatic model_eval();
        int unsigned nmatch;
        logic [3*mmu_pkg::VPN_W-1:0] vpn;
        logic [mmu_pkg::PLEN-1:0] pa;
        logic aerr;
        nmatch = 0;
        vpn    = req.vaddr[mmu_pkg::VLEN-1:mmu_pkg::PG_OFFS_W];
        s1     = '0;
        for (int i = 0; i < int'(mmu_pkg::TLB_ENTRIES); i++) begin
            if (m_valid[i] && (m_asid[i] == asid || m_pte[i].g) && vpn_covers(i, vpn)) begin
                nmatch++;
                s1.is_2m = m_2m[i];
                s1.is_1g = m_1g[i];
                s1.pte   = m_pte[i];
            end
        end
        s1.req      = req.req;
        s1.is_store = req.is_store;
        s1.vaddr    = req.vaddr;
        s1.hit      = en_translation && req.req && nmatch != 0;
        // overlapping entries leave the chosen one open
        s1_amb      = nmatch > 1;
        s1_missp    = en_translation && req.req && nmatch == 0;
        if (s1_missp) begin
            last_miss_vpn = vpn;
            have_miss     = 1'b1;
        end

        exp_miss = p1_missp;
        if (en_translation) begin
            exp_hit = s1.hit;
            exp_ppn = s1.pte.ppn;
            if (s1.is_2m) begin
                exp_ppn[8:0] = vpn[8:0];
            end
            if (s1.is_1g) begin
                exp_ppn[17:0] = vpn[17:0];
            end
            ppn_chk = s1.hit && !s1_amb;
        end else begin
            exp_hit = 1'b1;
            exp_ppn = mmu_pkg::PPNW'(vpn);
            ppn_chk = 1'b1;
        end

        // --------------------
        // response of the request from one cycle back
        // --------------------
        exp_resp       = '0;
        exp_resp.valid = p1.req;
        if (!en_translation) begin
            exp_resp.paddr = mmu_pkg::PLEN'(p1.vaddr);
            paddr_chk      = p1.req;
            ex_chk         = p1.req;
        end else begin
            pa = {p1.pte.ppn, p1.vaddr[11:0]};
            if (p1.is_2m) begin
                pa[20:12] = p1.vaddr[20:12];
            end
            if (p1.is_1g) begin
                pa[29:12] = p1.vaddr[29:12];
            end
            exp_resp.paddr = pa;
            exp_resp.miss  = p1.req && !p1.hit;
            paddr_chk      = p1.req && p1.hit && !p1_amb;
            ex_chk         = p1.req && !(p1.hit && p1_amb);
            aerr = (priv_lvl == mmu_pkg::PRIV_LVL_S && !sum && p1.pte.u) ||
                   (priv_lvl == mmu_pkg::PRIV_LVL_U && !p1.pte.u);
            if (p1.req && p1.hit) begin
                if (p1.is_store && (!p1.pte.w || !p1.pte.d || aerr)) begin
                    exp_resp.ex = '{cause: mmu_pkg::CAUSE_STORE_PAGE_FAULT,
                                    tval: p1.vaddr, valid: 1'b1};
                end else if (!p1.is_store && aerr) begin
                    exp_resp.ex = '{cause: mmu_pkg::CAUSE_LOAD_PAGE_FAULT,
                                    tval: p1.vaddr, valid: 1'b1};
                end
            end
        end
    endtask

    // --------------------
    // stimulus
    // --------------------
    task automatic drive_idle();
        req         = '0;
        update      = '0;
        flush       = 1'b0;
        flush_asid  = '0;
        flush_vaddr = '0;
    endtask

    task automatic drive_random(input logic translate);
        logic [mmu_pkg::VLEN-1:0] va;
        int unsigned sel;
        en_translation = translate;
        req.req        = rand_below(4) != 0;
        req.is_store   = rand_bit();
        if (translate) begin
            req.vaddr = pool_vaddr();
        end else begin
            req.vaddr = mmu_pkg::VLEN'({rand_next(), rand_next()});
        end
        sel = rand_below(3);
        priv_lvl = sel == 0 ? mmu_pkg::PRIV_LVL_U :
                   sel == 1 ? mmu_pkg::PRIV_LVL_S : mmu_pkg::PRIV_LVL_M;
        sum = rand_bit();
        // address space switches now and then
        if (rand_below(16) == 0) begin
            asid = mmu_pkg::ASID_W'(rand_below(4));
        end

        // walker refill, half of them for the last missed page
        update = '0;
        if (rand_below(4) == 0) begin
            va           = pool_vaddr();
            update.valid = 1'b1;
            update.vpn   = va[mmu_pkg::VLEN-1:mmu_pkg::PG_OFFS_W];
            update.asid  = mmu_pkg::ASID_W'(rand_below(4));
            if (have_miss && rand_bit()) begin
                update.vpn  = last_miss_vpn;
                update.asid = asid;
            end
            sel                 = rand_below(3);
            update.is_2m        = sel == 1;
            update.is_1g        = sel == 2;
            update.content.ppn  = mmu_pkg::PPNW'({rand_next(), rand_next()});
            update.content.d    = rand_bit();
            update.content.a    = rand_bit();
            update.content.g    = rand_below(4) == 0;
            update.content.u    = rand_bit();
            update.content.x    = rand_bit();
            update.content.w    = rand_bit();
            update.content.r    = rand_bit();
            update.content.v    = 1'b1;
        end

        flush       = rand_below(16) == 0;
        flush_asid  = rand_bit() ? mmu_pkg::ASID_W'(rand_below(4)) : '0;
        flush_vaddr = rand_bit() ? pool_vaddr() : '0;
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin : main
        lcg_state      = 32'd2118;
        chk_en         = 1'b0;
        rst_ni         = 1'b0;
        en_translation = 1'b0;
        priv_lvl       = mmu_pkg::PRIV_LVL_M;
        sum            = 1'b0;
        asid           = '0;
        drive_idle();
        model_reset();
        model_eval();

        repeat (2) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        model_eval();
        chk_en = 1'b1;

        // each phase opens with bare mode, then translation on
        for (int unsigned c = 0; c < NUM_CYCLES; c++) begin
            @(posedge clk_i);
            model_clock();
            #2;
            drive_random((c % PHASE_CYCLES) >= BARE_CYCLES);
            model_eval();
        end

        // drain the pipeline
        repeat (2) begin
            @(posedge clk_i);
            model_clock();
            #2;
            drive_idle();
            model_eval();
        end
        @(negedge clk_i);
        #1;

        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin : watchdog
        for (int unsigned n = 0; n < TIMEOUT_CYCLES; n++) begin
            @(posedge clk_i);
        end
        $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: sim.f
design/mmu_pkg.sv
design/dtlb.sv
design/lookup_stage.sv
design/translate_stage.sv
design/dmmu.sv
testbench/dmmu_checker.sv
testbench/tb_dmmu.sv

// File: run.sh
#!/bin/sh
# build the dmmu testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps -f sim.f --top-module tb_dmmu -o tb_dmmu
out=$(./obj_dir/tb_dmmu)
echo "$out"
echo "$out" | grep -q "NO ERRORS"
